// ==== filelist.f ====
hw/uscope_pkg.sv
hw/timebase.sv
hw/scope_capture.sv
hw/sample_fifo.sv
hw/dma_writer.sv
hw/uscope_top.sv
bench/uscope_chk.sv
bench/uscope_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module uscope_tb \
    -f filelist.f \
    -o Vuscope_tb

./obj_dir/Vuscope_tb | tee "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== bench/uscope_tb.sv ====
`timescale 1ns/1ps

module uscope_tb;
    import uscope_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DONE_LIMIT = 30000;

    logic       clock;
    logic       arst_n;
    scope_cfg_t cfg;
    logic       start;
    channels_t  channels;
    logic       mem_valid;
    mem_wr_t    mem;
    logic       mem_ready;
    logic       dma_done;
    logic       overrun;

    integer     seed = 32'h896b_98b3;
    int         ready_mode;
    int         errors;
    int         checks;
    int         tests;
    int         done_cnt;
    int         beat_idx;
    tb_count_t  model_cnt;
    logic       model_on;
    sample_t    strobe_q[$];

    uscope_top uut (
        .clock     (clock),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .start     (start),
        .channels  (channels),
        .mem_valid (mem_valid),
        .mem       (mem),
        .mem_ready (mem_ready),
        .dma_done  (dma_done),
        .overrun   (overrun)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Fresh channel data every cycle and a mem_ready pattern chosen by the current test
    always @(negedge clock) begin
        integer r;
        int     slot;
        for (int c = 0; c < N_CHANNELS; c++) begin
            r = $random(seed);
            channels[c] = r[15:0];
        end
        slot = int'($time / CLK_PERIOD);
        if (ready_mode == 0) begin
            mem_ready = 1'b1;
        end else if (ready_mode == 2) begin
            mem_ready = 1'b0;
        end else if (slot % 8 == 0) begin
            r = $random(seed);
            mem_ready = r[0];
        end
    end

    // Inputs are settled here and hold until the next rising edge
    always @(negedge clock) begin
        #1;
        if (arst_n) begin
            if (model_on && model_cnt == cfg.threshold) begin
                strobe_q.push_back(channels[cfg.channel_selector]);
            end
            if (dma_done) begin
                done_cnt++;
            end
            if (start) begin
                model_cnt = '0;
                model_on  = 1'b1;
                strobe_q.delete();
            end else if (model_cnt >= cfg.period - tb_count_t'(1)) begin
                model_cnt = '0;
            end else begin
                model_cnt = model_cnt + tb_count_t'(1);
            end
        end
    end

    function automatic mem_data_t ref_beat(trig_mode_t mode, sample_t level, int j);
        int        trig;
        int        idx;
        mem_data_t d;
        trig = -1;
        d = '0;
        for (int i = 0; i < strobe_q.size() && trig < 0; i++) begin
            if (mode == TRIG_FREE) begin
                trig = i;
            end else if (i > 0 && mode == TRIG_RISING) begin
                if (strobe_q[i-1] < level && strobe_q[i] >= level) trig = i;
            end else if (i > 0 && mode == TRIG_FALLING) begin
                if (strobe_q[i-1] >= level && strobe_q[i] < level) trig = i;
            end
        end
        if (trig < 0) return 'x;
        for (int k = 0; k < SAMPLES_PER_BEAT; k++) begin
            idx = trig + SAMPLES_PER_BEAT * j + k;
            if (idx >= strobe_q.size()) return 'x;
            d[16*k +: 16] = strobe_q[idx];
        end
        return d;
    endfunction

    task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error [%0t] %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Each accepted beat is checked against the model
    always @(negedge clock) begin
        #1;
        if (start) begin
            beat_idx = 0;
        end
        if (arst_n && mem_valid && mem_ready) begin
            check_value($sformatf("beat %0d address", beat_idx), 64'(mem.addr),
                        64'(cfg.buffer_addr + mem_addr_t'(BEAT_BYTES * beat_idx)));
            check_value($sformatf("beat %0d data", beat_idx), mem.data,
                        ref_beat(cfg.trigger_mode, cfg.trigger_level, beat_idx));
            beat_idx++;
        end
    end

    task automatic pulse_start();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic run_record(string name, trig_mode_t mode, chan_sel_t sel, sample_t level,
                              tb_count_t period, tb_count_t thr, mem_addr_t addr, int rmode);
        int n;
        int err0;
        err0 = errors;
        tests++;
        @(negedge clock);
        ready_mode = rmode;
        cfg = '{period: period, threshold: thr, trigger_mode: mode, trigger_level: level,
                channel_selector: sel, buffer_addr: addr};
        done_cnt = 0;
        pulse_start();
        n = 0;
        while (done_cnt == 0 && n < DONE_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (done_cnt == 0) begin
            errors++;
            $display("Test %s: dma_done never arrived", name);
        end
        repeat (4) @(negedge clock);
        #2;
        check_value("dma_done pulses", 64'(done_cnt), 64'd1);
        check_value("beats written", 64'(beat_idx), 64'(BEATS_PER_RECORD));
        check_value("overrun", 64'(overrun), 64'd0);
        $display("Test %s finished with %0d errors", name, errors - err0);
    endtask

    task automatic run_overrun();
        int n;
        int err0;
        err0 = errors;
        tests++;
        @(negedge clock);
        ready_mode = 2;
        cfg = '{period: 16'd3, threshold: 16'd1, trigger_mode: TRIG_FREE, trigger_level: '0,
                channel_selector: 2'd0, buffer_addr: 32'h0000_4000};
        pulse_start();
        n = 0;
        while (!overrun && n < DONE_LIMIT) begin
            @(negedge clock);
            #2;
            n++;
        end
        if (!overrun) begin
            errors++;
            $display("Test overrun: overrun never rose with the memory port stalled");
        end
        check_value("samples pending at overrun", 64'(strobe_q.size() > FIFO_DEPTH), 64'd1);
        pulse_start();
        #2;
        check_value("overrun after start", 64'(overrun), 64'd0);
        $display("Test overrun finished with %0d errors", errors - err0);
    endtask

    initial begin
        arst_n = 1'b0;
        start = 1'b0;
        cfg = '0;
        cfg.period = 16'd4;
        channels = '0;
        mem_ready = 1'b1;
        ready_mode = 0;
        model_on = 1'b0;
        model_cnt = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        done_cnt = 0;
        beat_idx = 0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        #2;
        check_value("mem_valid after reset", 64'(mem_valid), 64'd0);
        check_value("dma_done after reset", 64'(dma_done), 64'd0);
        check_value("overrun after reset", 64'(overrun), 64'd0);
        run_record("free run", TRIG_FREE, 2'd0, '0, 16'd4, 16'd2, 32'h0000_1000, 0);
        run_record("rising ch2", TRIG_RISING, 2'd2, '0, 16'd5, 16'd1, 32'h0000_2000, 0);
        run_record("falling ch1", TRIG_FALLING, 2'd1, 16'sd1000, 16'd7, 16'd3, 32'h0000_3000, 0);
        run_record("mem stalls", TRIG_FREE, 2'd3, '0, 16'd6, 16'd5, 32'h0001_0000, 1);
        run_overrun();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/uscope_chk.sv ====
`timescale 1ns/1ps

module uscope_chk (
    input logic                        clock,
    input logic                        arst_n,
    input logic                        mem_valid,
    input uscope_pkg::mem_wr_t         mem,
    input logic                        mem_ready,
    input logic                        dma_done,
    input logic                        in_valid,
    input logic                        in_ready,
    input logic                        out_valid,
    input uscope_pkg::fifo_count_t     fifo_count
);
    import uscope_pkg::*;

    // A stalled beat must hold both its address and its data
    mem_stable: assert property (@(posedge clock) disable iff (!arst_n)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem)))
        else $error("memory beat changed while stalled");

    done_single: assert property (@(posedge clock) disable iff (!arst_n)
        dma_done |=> !dma_done)
        else $error("dma_done longer than one cycle");

    // An empty FIFO only offers data after something has been pushed into it
    empty_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        ((fifo_count == '0) && !(in_valid && in_ready)) |=> !out_valid)
        else $error("out_valid rose with an empty FIFO and no push");

endmodule

bind uscope_top uscope_chk u_chk (
    .clock      (clock),
    .arst_n     (arst_n),
    .mem_valid  (mem_valid),
    .mem        (mem),
    .mem_ready  (mem_ready),
    .dma_done   (dma_done),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .fifo_count (u_fifo.count)
);

// ==== hw/uscope_top.sv ====
`timescale 1ns/1ps

module uscope_top (
    input  logic                   clock,
    input  logic                   arst_n,
    input  uscope_pkg::scope_cfg_t cfg,
    input  logic                   start,
    input  uscope_pkg::channels_t  channels,
    output logic                   mem_valid,
    output uscope_pkg::mem_wr_t    mem,
    input  logic                   mem_ready,
    output logic                   dma_done,
    output logic                   overrun
);
    import uscope_pkg::*;

    logic    in_valid;
    logic    in_ready;
    sample_t in_data;
    logic    out_valid;
    logic    out_ready;
    sample_t out_data;

    scope_capture u_capture (
        .clock    (clock),
        .arst_n   (arst_n),
        .start    (start),
        .cfg      (cfg),
        .channels (channels),
        .active   (),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .overrun  (overrun)
    );

    sample_fifo u_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    dma_writer u_writer (
        .clock       (clock),
        .arst_n      (arst_n),
        .start       (start),
        .buffer_addr (cfg.buffer_addr),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .mem_valid   (mem_valid),
        .mem         (mem),
        .mem_ready   (mem_ready),
        .dma_done    (dma_done)
    );

endmodule

// ==== hw/dma_writer.sv ====
`timescale 1ns/1ps

module dma_writer (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  uscope_pkg::mem_addr_t buffer_addr,
    input  logic                  out_valid,
    input  uscope_pkg::sample_t   out_data,
    output logic                  out_ready,
    output logic                  mem_valid,
    output uscope_pkg::mem_wr_t   mem,
    input  logic                  mem_ready,
    output logic                  dma_done
);
    import uscope_pkg::*;

    lane_t       lane_q;
    beat_count_t beat_cnt_q;
    mem_addr_t   addr_q;
    mem_data_t   beat_q;
    logic        valid_q;
    logic        done_q;
    logic        take;
    logic        send;
    logic        last_beat;
    logic        idle;

    // A new sample may only enter the beat register once the pending beat leaves it
    assign out_ready = !valid_q || mem_ready;
    assign take      = out_valid && out_ready;
    assign send      = valid_q && mem_ready;
    assign last_beat = (beat_cnt_q == beat_count_t'(BEATS_PER_RECORD - 1));
    assign idle      = !valid_q && (lane_q == '0) && (beat_cnt_q == '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lane_q     <= '0;
            beat_cnt_q <= '0;
            addr_q     <= '0;
            valid_q    <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= send && last_beat;

            if (take) begin
                lane_q <= lane_q + lane_t'(1);
            end

            if (take && (lane_q == lane_t'(SAMPLES_PER_BEAT - 1))) begin
                valid_q <= 1'b1;
            end else if (send) begin
                valid_q <= 1'b0;
            end

            if (send) begin
                if (last_beat) begin
                    // Rewind for the next record
                    beat_cnt_q <= '0;
                    addr_q     <= buffer_addr;
                end else begin
                    beat_cnt_q <= beat_cnt_q + beat_count_t'(1);
                    addr_q     <= addr_q + mem_addr_t'(BEAT_BYTES);
                end
            end else if (start && idle) begin
                addr_q <= buffer_addr;
            end
        end
    end

    // Sample k of a beat lands in lane k, lowest lane in the low bits
    always_ff @(posedge clock) begin
        if (take) begin
            beat_q[int'(lane_q) * $bits(sample_t) +: $bits(sample_t)] <= out_data;
        end
    end

    assign mem_valid = valid_q;
    assign mem       = '{addr: addr_q, data: beat_q};
    assign dma_done  = done_q;

endmodule

// ==== hw/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                in_valid,
    input  uscope_pkg::sample_t in_data,
    output logic                in_ready,
    output logic                out_valid,
    output uscope_pkg::sample_t out_data,
    input  logic                out_ready
);
    import uscope_pkg::*;

    sample_t     mem_q [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr_q;
    fifo_ptr_t   rd_ptr_q;
    fifo_count_t count;
    logic        push;
    logic        pop;

    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + fifo_ptr_t'(1);
    endfunction

    assign in_ready  = (count != fifo_count_t'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem_q[rd_ptr_q];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leave the occupancy unchanged
            case ({push, pop})
                2'b10:   count <= count + fifo_count_t'(1);
                2'b01:   count <= count - fifo_count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/scope_capture.sv ====
`timescale 1ns/1ps

module scope_capture (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   start,
    input  uscope_pkg::scope_cfg_t cfg,
    input  uscope_pkg::channels_t  channels,
    output logic                   active,
    output logic                   in_valid,
    output uscope_pkg::sample_t    in_data,
    input  logic                   in_ready,
    output logic                   overrun
);
    import uscope_pkg::*;

    cap_state_t state_q;
    rec_count_t rec_cnt_q;
    sample_t    cur_sample;
    sample_t    level;
    sample_t    last_q;
    logic       have_prev_q;
    logic       valid_q;
    logic       overrun_q;
    logic       strobe;
    logic       arm;
    logic       fire;
    logic       take;

    // A start pulse is only honoured from idle
    assign arm        = start && (state_q == ST_IDLE);
    assign active     = (state_q != ST_IDLE);
    assign cur_sample = channels[cfg.channel_selector];
    assign level      = cfg.trigger_level;

    timebase u_timebase (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (arm),
        .active    (active),
        .period    (cfg.period),
        .threshold (cfg.threshold),
        .strobe    (strobe)
    );

    // Crossing detection needs a previous sample, so the first strobe after arming
    // can only fire in free run
    always_comb begin
        case (cfg.trigger_mode)
            TRIG_RISING:  fire = have_prev_q && (last_q < level) && (cur_sample >= level);
            TRIG_FALLING: fire = have_prev_q && (last_q >= level) && (cur_sample < level);
            TRIG_FREE:    fire = 1'b1;
            default:      fire = 1'b0;
        endcase
    end

    // The trigger sample itself is record sample 0
    assign take = strobe && ((state_q == ST_RECORD) || ((state_q == ST_ARMED) && fire));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ST_IDLE;
            rec_cnt_q   <= '0;
            have_prev_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (arm) begin
                        state_q     <= ST_ARMED;
                        have_prev_q <= 1'b0;
                    end
                end
                ST_ARMED: begin
                    if (strobe) begin
                        have_prev_q <= 1'b1;
                        if (fire) begin
                            state_q   <= ST_RECORD;
                            rec_cnt_q <= rec_count_t'(1);
                        end
                    end
                end
                ST_RECORD: begin
                    if (strobe) begin
                        if (rec_cnt_q == rec_count_t'(RECORD_LEN - 1)) begin
                            state_q   <= ST_IDLE;
                            rec_cnt_q <= '0;
                        end else begin
                            rec_cnt_q <= rec_cnt_q + rec_count_t'(1);
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Latched at every strobe, it is both the crossing reference and the FIFO payload
    always_ff @(posedge clock) begin
        if (strobe) begin
            last_q <= cur_sample;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            valid_q <= take;
            // Offered for one cycle only, a refused sample is lost
            if (start) begin
                overrun_q <= 1'b0;
            end else if (valid_q && !in_ready) begin
                overrun_q <= 1'b1;
            end
        end
    end

    assign in_valid = valid_q;
    assign in_data  = last_q;
    assign overrun  = overrun_q;

endmodule

// ==== hw/timebase.sv ====
`timescale 1ns/1ps

module timebase (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  active,
    input  uscope_pkg::tb_count_t period,
    input  uscope_pkg::tb_count_t threshold,
    output logic                  strobe
);
    import uscope_pkg::*;

    tb_count_t count_q;
    tb_count_t last_count;

    // A period of 0 wraps at the full counter range
    assign last_count = period - tb_count_t'(1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (start) begin
            count_q <= '0;
        end else if (count_q >= last_count) begin
            // Also catches a period that was shortened below the current count
            count_q <= '0;
        end else begin
            count_q <= count_q + tb_count_t'(1);
        end
    end

    // The strobe lands threshold cycles into each period, only while a capture runs
    assign strobe = active && (count_q == threshold);

endmodule

// ==== hw/uscope_pkg.sv ====
package uscope_pkg;

    // Record geometry and buffering
    localparam int N_CHANNELS       = 4;
    localparam int RECORD_LEN       = 64;
    localparam int SAMPLES_PER_BEAT = 4;
    localparam int FIFO_DEPTH       = 16;
    localparam int BEAT_BYTES       = 8;
    localparam int BEATS_PER_RECORD = RECORD_LEN / SAMPLES_PER_BEAT;

    localparam int CHAN_SEL_W = $clog2(N_CHANNELS);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int REC_CNT_W  = $clog2(RECORD_LEN);
    localparam int BEAT_CNT_W = $clog2(BEATS_PER_RECORD);
    localparam int LANE_W     = $clog2(SAMPLES_PER_BEAT);

    typedef logic signed [15:0] sample_t;
    typedef logic [31:0] mem_addr_t;
    typedef logic [63:0] mem_data_t;
    typedef logic [15:0] tb_count_t;
    typedef logic [1:0] trig_mode_t;
    typedef logic [CHAN_SEL_W-1:0] chan_sel_t;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    // One extra bit so that a full FIFO can be told apart from an empty one
    typedef logic [FIFO_PTR_W:0] fifo_count_t;
    typedef logic [REC_CNT_W-1:0] rec_count_t;
    typedef logic [BEAT_CNT_W-1:0] beat_count_t;
    typedef logic [LANE_W-1:0] lane_t;

    // Trigger modes, code 3 is reserved
    localparam trig_mode_t TRIG_RISING  = 2'd0;
    localparam trig_mode_t TRIG_FALLING = 2'd1;
    localparam trig_mode_t TRIG_FREE    = 2'd2;

    // Capture state register codes
    typedef logic [1:0] cap_state_t;
    localparam cap_state_t ST_IDLE   = 2'd0;
    localparam cap_state_t ST_ARMED  = 2'd1;
    localparam cap_state_t ST_RECORD = 2'd2;

    typedef sample_t [N_CHANNELS-1:0] channels_t;

    typedef struct packed {
        tb_count_t  period;
        tb_count_t  threshold;
        trig_mode_t trigger_mode;
        sample_t    trigger_level;
        chan_sel_t  channel_selector;
        mem_addr_t  buffer_addr;
    } scope_cfg_t;

    typedef struct packed {
        mem_addr_t addr;
        mem_data_t data;
    } mem_wr_t;

endpackage
